// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= tb_mips_system
FILELIST  ?= verilog.f

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

// ==== hw/data_bus_if.sv ====
`timescale 1ns/1ps

interface data_bus_if;

        mips_pkg::word_t address;
        mips_pkg::word_t writedata;
        logic            write;
        logic            read;
        mips_pkg::word_t readdata;

        modport cpu (
                output address,
                output writedata,
                output write,
                output read,
                input  readdata
        );

        modport mem (
                input  address,
                input  writedata,
                input  write,
                input  read,
                output readdata
        );

endinterface

// ==== hw/data_memory.sv ====
`timescale 1ns/1ps

module data_memory (
        input logic     clk,
        input logic     rst_n,
        input logic     clk_enable,
        data_bus_if.mem bus
);

        mips_pkg::word_t                 mem [mips_pkg::dmem_words];
        logic [mips_pkg::dmem_idx_w-1:0] idx;

        // Word index, the byte offset is dropped
        assign idx = bus.address[mips_pkg::dmem_idx_w+1:2];

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < mips_pkg::dmem_words; i++) begin
                                mem[i] <= '0;
                        end
                end else if (bus.write && clk_enable) begin
                        mem[idx] <= bus.writedata;
                end
        end

        assign bus.readdata = mem[idx];

        a_word_aligned: assert property (
                @(posedge clk) disable iff (!rst_n)
                (bus.read || bus.write) |-> (bus.address[1:0] == 2'b00)
        );

endmodule

// ==== hw/mips_alu.sv ====
`timescale 1ns/1ps

module mips_alu (
        input  mips_pkg::alu_op_e  op,
        input  mips_pkg::word_t    a,
        input  mips_pkg::word_t    b,
        input  logic [4:0]         shamt,
        input  mips_pkg::br_cond_e cond,
        output mips_pkg::word_t    result,
        output logic               taken
);

        logic a_zero;
        logic a_neg;
        logic lt_signed;
        logic lt_unsigned;

        assign a_zero      = (a == '0);
        assign a_neg       = a[31];
        assign lt_signed   = $signed(a) < $signed(b);
        assign lt_unsigned = a < b;

        always_comb begin
                case (op)
                        mips_pkg::alu_add:  result = a + b;
                        mips_pkg::alu_sub:  result = a - b;
                        mips_pkg::alu_and:  result = a & b;
                        mips_pkg::alu_or:   result = a | b;
                        mips_pkg::alu_xor:  result = a ^ b;
                        mips_pkg::alu_slt:  result = {31'b0, lt_signed};
                        mips_pkg::alu_sltu: result = {31'b0, lt_unsigned};
                        // Shift amount comes from the instruction, not rs
                        mips_pkg::alu_sll:  result = b << shamt;
                        mips_pkg::alu_srl:  result = b >> shamt;
                        mips_pkg::alu_sra:  result = $signed(b) >>> shamt;
                        mips_pkg::alu_lui:  result = {b[15:0], 16'h0000};
                        default:            result = '0;
                endcase
        end

        ////////////////////////////////////////////////////////////////////
        // Branch condition
        ////////////////////////////////////////////////////////////////////

        always_comb begin
                case (cond)
                        mips_pkg::br_eq:  taken = (a == b);
                        mips_pkg::br_ne:  taken = (a != b);
                        mips_pkg::br_lez: taken = a_neg || a_zero;
                        mips_pkg::br_gtz: taken = !a_neg && !a_zero;
                        default:          taken = 1'b0;
                endcase
        end

endmodule

// ==== hw/mips_cpu_harvard.sv ====
`timescale 1ns/1ps

module mips_cpu_harvard (
        input  logic            clk,
        input  logic            rst_n,
        input  logic            clk_enable,
        input  mips_pkg::word_t instr_readdata,
        output logic            active,
        output mips_pkg::word_t register_v0,
        output mips_pkg::word_t instr_address,
        data_bus_if.cpu         dbus
);

        mips_pkg::word_t    pc;
        mips_pkg::word_t    next_pc;
        mips_pkg::word_t    following_pc;
        mips_pkg::word_t    branch_target;
        mips_pkg::word_t    link_addr;
        mips_pkg::word_t    imm_ext;
        mips_pkg::word_t    rs_data;
        mips_pkg::word_t    rt_data;
        mips_pkg::word_t    alu_b;
        mips_pkg::word_t    alu_result;
        mips_pkg::word_t    wb_data;
        mips_pkg::reg_idx_t rs;
        mips_pkg::reg_idx_t rt;
        mips_pkg::reg_idx_t rd;
        mips_pkg::reg_idx_t wr_idx;
        logic [4:0]         shamt;
        logic [15:0]        imm;
        logic [25:0]        target;
        mips_pkg::ctrl_t    ctrl;
        logic               taken;
        logic               at_halt;
        logic               retire;

        mips_decoder u_decoder (
                .instr  (instr_readdata),
                .rs     (rs),
                .rt     (rt),
                .rd     (rd),
                .shamt  (shamt),
                .imm    (imm),
                .target (target),
                .ctrl   (ctrl)
        );

        mips_regfile u_regfile (
                .clk       (clk),
                .rst_n     (rst_n),
                .wr_en     (retire && ctrl.reg_write),
                .wr_idx    (wr_idx),
                .wr_data   (wb_data),
                .rd_idx_a  (rs),
                .rd_idx_b  (rt),
                .rd_data_a (rs_data),
                .rd_data_b (rt_data),
                .v0        (register_v0)
        );

        mips_alu u_alu (
                .op     (ctrl.alu_op),
                .a      (rs_data),
                .b      (alu_b),
                .shamt  (shamt),
                .cond   (ctrl.br_cond),
                .result (alu_result),
                .taken  (taken)
        );

        assign imm_ext = ctrl.zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
        assign alu_b   = ctrl.use_imm ? imm_ext : rt_data;

        ////////////////////////////////////////////////////////////////////
        // Fetch sequencing and halt
        ////////////////////////////////////////////////////////////////////

        assign instr_address = pc;
        assign at_halt       = (pc == mips_pkg::halt_address);
        assign retire        = active && clk_enable && !at_halt;

        // Targets are relative to the delay slot
        assign branch_target = next_pc + {{14{imm[15]}}, imm, 2'b00};
        assign link_addr     = pc + 32'd8;

        always_comb begin
                if (ctrl.jump_reg)
                        following_pc = rs_data;
                else if (ctrl.jump)
                        following_pc = {next_pc[31:28], target, 2'b00};
                else if (taken)
                        following_pc = branch_target;
                else
                        following_pc = next_pc + 32'd4;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        pc      <= mips_pkg::reset_vector;
                        next_pc <= mips_pkg::reset_vector + 32'd4;
                        active  <= 1'b1;
                end else if (retire) begin
                        pc      <= next_pc;
                        next_pc <= following_pc;
                end else if (active && clk_enable) begin
                        active  <= 1'b0;
                end
        end

        // Write-back and data port
        always_comb begin
                case (ctrl.dest_sel)
                        mips_pkg::dest_rt:  wr_idx = rt;
                        mips_pkg::dest_r31: wr_idx = mips_pkg::ra_index;
                        default:            wr_idx = rd;
                endcase
        end

        assign wb_data = ctrl.jump     ? link_addr :
                         ctrl.mem_read ? dbus.readdata : alu_result;

        assign dbus.address   = alu_result;
        assign dbus.writedata = rt_data;
        assign dbus.write     = retire && ctrl.mem_write;
        assign dbus.read      = retire && ctrl.mem_read;

        a_strobes_exclusive: assert property (
                @(posedge clk) disable iff (!rst_n) !(dbus.read && dbus.write)
        );

        // Once halted the core stays frozen until reset
        a_halt_frozen: assert property (
                @(posedge clk) disable iff (!rst_n)
                !active |=> !active && !dbus.write && $stable(register_v0)
        );

        a_known_encoding: assert property (
                @(posedge clk) disable iff (!rst_n) retire |-> !ctrl.illegal
        );

endmodule

// ==== hw/mips_decoder.sv ====
`timescale 1ns/1ps

module mips_decoder (
        input  mips_pkg::word_t    instr,
        output mips_pkg::reg_idx_t rs,
        output mips_pkg::reg_idx_t rt,
        output mips_pkg::reg_idx_t rd,
        output logic [4:0]         shamt,
        output logic [15:0]        imm,
        output logic [25:0]        target,
        output mips_pkg::ctrl_t    ctrl
);

        logic [5:0] opcode;
        logic [5:0] funct;

        assign opcode = instr[31:26];
        assign rs     = instr[25:21];
        assign rt     = instr[20:16];
        assign rd     = instr[15:11];
        assign shamt  = instr[10:6];
        assign funct  = instr[5:0];
        assign imm    = instr[15:0];
        assign target = instr[25:0];

        always_comb begin
                ctrl = '0;
                case (opcode)
                        mips_pkg::op_special: begin
                                ctrl.reg_write = 1'b1;
                                ctrl.dest_sel  = mips_pkg::dest_rd;
                                case (funct)
                                        mips_pkg::fn_sll:  ctrl.alu_op = mips_pkg::alu_sll;
                                        mips_pkg::fn_srl:  ctrl.alu_op = mips_pkg::alu_srl;
                                        mips_pkg::fn_sra:  ctrl.alu_op = mips_pkg::alu_sra;
                                        mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
                                        mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
                                        mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
                                        mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
                                        mips_pkg::fn_xor:  ctrl.alu_op = mips_pkg::alu_xor;
                                        mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
                                        mips_pkg::fn_sltu: ctrl.alu_op = mips_pkg::alu_sltu;
                                        mips_pkg::fn_jr: begin
                                                ctrl.reg_write = 1'b0;
                                                ctrl.jump      = 1'b1;
                                                ctrl.jump_reg  = 1'b1;
                                        end
                                        // Link goes to rd
                                        mips_pkg::fn_jalr: begin
                                                ctrl.jump     = 1'b1;
                                                ctrl.jump_reg = 1'b1;
                                        end
                                        default: begin
                                                ctrl.reg_write = 1'b0;
                                                ctrl.illegal   = 1'b1;
                                        end
                                endcase
                        end
                        mips_pkg::op_j:    ctrl.jump = 1'b1;
                        mips_pkg::op_jal: begin
                                ctrl.jump      = 1'b1;
                                ctrl.reg_write = 1'b1;
                                ctrl.dest_sel  = mips_pkg::dest_r31;
                        end
                        mips_pkg::op_beq:  ctrl.br_cond = mips_pkg::br_eq;
                        mips_pkg::op_bne:  ctrl.br_cond = mips_pkg::br_ne;
                        mips_pkg::op_blez: ctrl.br_cond = mips_pkg::br_lez;
                        mips_pkg::op_bgtz: ctrl.br_cond = mips_pkg::br_gtz;
                        mips_pkg::op_addiu, mips_pkg::op_andi, mips_pkg::op_ori,
                        mips_pkg::op_lui, mips_pkg::op_lw: begin
                                ctrl.use_imm   = 1'b1;
                                ctrl.reg_write = 1'b1;
                                ctrl.dest_sel  = mips_pkg::dest_rt;
                                ctrl.mem_read  = (opcode == mips_pkg::op_lw);
                                ctrl.zero_ext  = (opcode == mips_pkg::op_andi) ||
                                                 (opcode == mips_pkg::op_ori);
                                case (opcode)
                                        mips_pkg::op_andi: ctrl.alu_op = mips_pkg::alu_and;
                                        mips_pkg::op_ori:  ctrl.alu_op = mips_pkg::alu_or;
                                        mips_pkg::op_lui:  ctrl.alu_op = mips_pkg::alu_lui;
                                        default:           ctrl.alu_op = mips_pkg::alu_add;
                                endcase
                        end
                        mips_pkg::op_sw: begin
                                ctrl.use_imm   = 1'b1;
                                ctrl.mem_write = 1'b1;
                        end
                        default: ctrl.illegal = 1'b1;
                endcase
        end

endmodule

// ==== hw/mips_pkg.sv ====
package mips_pkg;

        typedef logic [31:0] word_t;
        typedef logic [4:0]  reg_idx_t;

        localparam word_t    reset_vector = 32'hbfc0_0000;
        localparam word_t    halt_address = 32'h0000_0000;
        localparam int       reg_count    = 32;
        localparam int       dmem_words   = 1024;
        localparam int       dmem_idx_w   = $clog2(dmem_words);
        localparam reg_idx_t v0_index     = 5'd2;
        localparam reg_idx_t ra_index     = 5'd31;

        ////////////////////////////////////////////////////////////////////
        // Instruction encodings
        ////////////////////////////////////////////////////////////////////

        typedef enum logic [5:0] {
                op_special = 6'h00, op_j    = 6'h02, op_jal  = 6'h03,
                op_beq     = 6'h04, op_bne  = 6'h05, op_blez = 6'h06,
                op_bgtz    = 6'h07, op_addiu = 6'h09, op_andi = 6'h0c,
                op_ori     = 6'h0d, op_lui  = 6'h0f, op_lw   = 6'h23,
                op_sw      = 6'h2b
        } opcode_e;

        // SPECIAL group, selected by the low six bits
        typedef enum logic [5:0] {
                fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra  = 6'h03,
                fn_jr   = 6'h08, fn_jalr = 6'h09, fn_addu = 6'h21,
                fn_subu = 6'h23, fn_and  = 6'h24, fn_or   = 6'h25,
                fn_xor  = 6'h26, fn_slt  = 6'h2a, fn_sltu = 6'h2b
        } funct_e;

        ////////////////////////////////////////////////////////////////////
        // Datapath control
        ////////////////////////////////////////////////////////////////////

        typedef enum logic [3:0] {
                alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
                alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
        } alu_op_e;

        typedef enum logic [2:0] {
                br_none, br_eq, br_ne, br_lez, br_gtz
        } br_cond_e;

        typedef enum logic [1:0] {
                dest_rd, dest_rt, dest_r31
        } dest_sel_e;

        // All-zero word is a no-op
        typedef struct packed {
                alu_op_e   alu_op;
                br_cond_e  br_cond;
                logic      use_imm;
                logic      zero_ext;
                logic      reg_write;
                dest_sel_e dest_sel;
                logic      mem_read;
                logic      mem_write;
                logic      jump;
                logic      jump_reg;
                logic      illegal;
        } ctrl_t;

endpackage

// ==== hw/mips_regfile.sv ====
`timescale 1ns/1ps

module mips_regfile (
        input  logic               clk,
        input  logic               rst_n,
        input  logic               wr_en,
        input  mips_pkg::reg_idx_t wr_idx,
        input  mips_pkg::word_t    wr_data,
        input  mips_pkg::reg_idx_t rd_idx_a,
        input  mips_pkg::reg_idx_t rd_idx_b,
        output mips_pkg::word_t    rd_data_a,
        output mips_pkg::word_t    rd_data_b,
        output mips_pkg::word_t    v0
);

        mips_pkg::word_t regs [mips_pkg::reg_count];

        // r0 keeps its reset value forever
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < mips_pkg::reg_count; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wr_en && (wr_idx != '0)) begin
                        regs[wr_idx] <= wr_data;
                end
        end

        assign rd_data_a = regs[rd_idx_a];
        assign rd_data_b = regs[rd_idx_b];
        assign v0        = regs[mips_pkg::v0_index];

endmodule

// ==== hw/mips_system.sv ====
`timescale 1ns/1ps

module mips_system (
        input  logic            clk,
        input  logic            rst_n,
        input  logic            clk_enable,
        output logic            active,
        output mips_pkg::word_t register_v0,
        output mips_pkg::word_t instr_address,
        input  mips_pkg::word_t instr_readdata
);

        data_bus_if dbus ();

        mips_cpu_harvard u_cpu (
                .clk            (clk),
                .rst_n          (rst_n),
                .clk_enable     (clk_enable),
                .instr_readdata (instr_readdata),
                .active         (active),
                .register_v0    (register_v0),
                .instr_address  (instr_address),
                .dbus           (dbus)
        );

        data_memory u_dmem (
                .clk        (clk),
                .rst_n      (rst_n),
                .clk_enable (clk_enable),
                .bus        (dbus)
        );

endmodule

// ==== tests/mips_checker.sv ====
`timescale 1ns/1ps

module mips_checker (
        input logic            clk,
        input logic            rst_n,
        input logic            active,
        input mips_pkg::word_t register_v0,
        input mips_pkg::word_t instr_address,
        input mips_pkg::word_t expected_v0,
        input int              test_num,
        input logic            run_timeout
);

        int              pass_count = 0;
        int              fail_count = 0;
        logic            was_active;
        logic            halted;
        mips_pkg::word_t held_v0;

        // v0 is judged at the first edge that sees active low
        always @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        was_active <= 1'b1;
                        halted     <= 1'b0;
                end else begin
                        was_active <= active;
                        if (run_timeout) begin
                                fail_count <= fail_count + 1;
                                $display("test %0d: core never halted, active stayed high",
                                         test_num);
                        end else if (was_active && !active) begin
                                held_v0 <= register_v0;
                                halted  <= 1'b1;
                                if (instr_address !== mips_pkg::halt_address) begin
                                        fail_count <= fail_count + 1;
                                        $display("FAIL test %0d instr_address expected %h got %h",
                                                 test_num, mips_pkg::halt_address,
                                                 instr_address);
                                end else if (register_v0 === expected_v0) begin
                                        pass_count <= pass_count + 1;
                                        $display("PASS test %0d register_v0 %h",
                                                 test_num, register_v0);
                                end else begin
                                        fail_count <= fail_count + 1;
                                        $display("FAIL test %0d register_v0 expected %h got %h",
                                                 test_num, expected_v0, register_v0);
                                end
                        end else if (halted && (register_v0 !== held_v0 || active)) begin
                                // Report once per run
                                halted     <= 1'b0;
                                fail_count <= fail_count + 1;
                                $display("test %0d: core state moved after it halted",
                                         test_num);
                        end
                end
        end

endmodule

// ==== tests/tb_mips_system.sv ====
`timescale 1ns/1ps

module tb_mips_system;

        localparam int n_tests         = 5;
        localparam int halt_limit      = 40;
        localparam int idle_cycles     = 20;
        localparam int watchdog_cycles = n_tests * (64 + 8);

        ////////////////////////////////////////////////////////////////////
        // Programs and expected v0
        ////////////////////////////////////////////////////////////////////

        localparam mips_pkg::word_t programs [n_tests][16] = '{
                '{32'h24080005, 32'h3c091234, 32'h352900f0, 32'h01091021,
                  32'h00481023, 32'h00025402, 32'h004a1026, 32'h240bfff8,
                  32'h000b6083, 32'h0188682a, 32'h010c702b, 32'h000d6a00,
                  32'h01ae6825, 32'h01ac6824, 32'h00000008, 32'h004d1025},
                '{32'h24080011, 32'h24090022, 32'hac080000, 32'hac090004,
                  32'h240a0100, 32'had490010, 32'h8c020000, 32'h8c0b0004,
                  32'h8d4c0010, 32'h004b1021, 32'h00000008, 32'h004c1021,
                  32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000},
                '{32'h24080001, 32'h11080002, 32'h24420040, 32'h24421000,
                  32'h15000002, 32'h24420020, 32'h24421000, 32'h19000002,
                  32'h24420010, 32'h24420008, 32'h1c000002, 32'h24420004,
                  32'h1d000002, 32'h24420004, 32'h24421000, 32'h00000008},
                '{32'h3c09bfc0, 32'h35290038, 32'h0ff0000c, 32'h24020001,
                  32'h01205009, 32'h005f1021, 32'h004a1021, 32'h00000008,
                  32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
                  32'h03e00008, 32'h00000000, 32'h01400008, 32'h00000000},
                '{32'h24080005, 32'h3c091234, 32'h352900f0, 32'h01091021,
                  32'h00481023, 32'h00025402, 32'h004a1026, 32'h240bfff8,
                  32'h000b6083, 32'h0188682a, 32'h010c702b, 32'h000d6a00,
                  32'h01ae6825, 32'h01ac6824, 32'h00000008, 32'h004d1025}
        };

        // 0x123412c4 | 0x100, 0x11 + 0x22 + 0x22, 128, 2 * 0xbfc00010 + 9
        localparam mips_pkg::word_t expected [n_tests] = '{
                32'h123413c4, 32'h00000055, 32'h00000080, 32'h7f800029, 32'h123413c4
        };
        localparam bit stalled [n_tests] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

        logic            clk;
        logic            rst_n;
        logic            clk_enable;
        logic            active;
        logic            run_timeout;
        mips_pkg::word_t register_v0;
        mips_pkg::word_t instr_address;
        mips_pkg::word_t instr_readdata;
        mips_pkg::word_t expected_v0;
        mips_pkg::word_t offset;
        mips_pkg::word_t rom [16];
        logic [31:0]     rand_state;
        int              test_num;

        always #4 clk = ~clk;

        // Instruction ROM, nop outside the program
        always_comb begin
                offset = instr_address - mips_pkg::reset_vector;
                if (offset < 32'd64)
                        instr_readdata = rom[offset[5:2]];
                else
                        instr_readdata = '0;
        end

        mips_system uut (
                .clk            (clk),
                .rst_n          (rst_n),
                .clk_enable     (clk_enable),
                .active         (active),
                .register_v0    (register_v0),
                .instr_address  (instr_address),
                .instr_readdata (instr_readdata)
        );

        mips_checker u_check (
                .clk           (clk),
                .rst_n         (rst_n),
                .active        (active),
                .register_v0   (register_v0),
                .instr_address (instr_address),
                .expected_v0   (expected_v0),
                .test_num      (test_num),
                .run_timeout   (run_timeout)
        );

        function automatic logic [31:0] xorshift(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        // Low about a third of the time when stalling
        task automatic drive_enable(input bit stall);
                rand_state = xorshift(rand_state);
                clk_enable <= stall ? ((rand_state % 3) != 0) : 1'b1;
        endtask

        task automatic run_program(input int t);
                int cycles;
                @(posedge clk);
                rst_n       <= 1'b0;
                clk_enable  <= 1'b0;
                run_timeout <= 1'b0;
                expected_v0 <= expected[t];
                test_num    <= t + 1;
                rom = programs[t];
                repeat (3) @(posedge clk);
                rst_n <= 1'b1;
                cycles = 0;
                while (cycles < halt_limit) begin
                        @(posedge clk);
                        if (!active)
                                break;
                        drive_enable(stalled[t]);
                        cycles++;
                end
                if (cycles >= halt_limit) begin
                        run_timeout <= 1'b1;
                        @(posedge clk);
                        run_timeout <= 1'b0;
                end
                repeat (idle_cycles) begin
                        @(posedge clk);
                        drive_enable(stalled[t]);
                end
        endtask

        initial begin
                clk         = 1'b0;
                rst_n       = 1'b0;
                clk_enable  = 1'b0;
                run_timeout = 1'b0;
                expected_v0 = '0;
                test_num    = 0;
                rand_state  = 32'd47054;
                rom         = '{default: '0};
                for (int t = 0; t < n_tests; t++) begin
                        run_program(t);
                end
                @(posedge clk);
                $display("tests %0d, passed %0d, failed %0d",
                         n_tests, u_check.pass_count, u_check.fail_count);
                if (u_check.fail_count == 0 && u_check.pass_count == n_tests) begin
                        $display("TB PASSED");
                end else begin
                        $display("TB FAILED");
                end
                $finish;
        end

        initial begin
                #(watchdog_cycles * 8);
                $display("watchdog expired after %0d cycles, the run did not finish",
                         watchdog_cycles);
                $display("TB FAILED");
                $finish;
        end

endmodule

// ==== verilog.f ====
hw/mips_pkg.sv
hw/data_bus_if.sv
hw/mips_decoder.sv
hw/mips_alu.sv
hw/mips_regfile.sv
hw/mips_cpu_harvard.sv
hw/data_memory.sv
hw/mips_system.sv
tests/mips_checker.sv
tests/tb_mips_system.sv
